// File: src/clock_pkg.sv
`default_nettype none

package clock_pkg;

    // ********************
    // Time and config words

    typedef struct packed {
        logic [3:0] hours;              // 1 to 12
        logic [5:0] minutes;            // 0 to 59
        logic [5:0] seconds;            // 0 to 59
    } clock_time_t;

    typedef struct packed {
        logic [3:0] hr_10s;
        logic [3:0] hr_1s;
        logic [3:0] min_10s;
        logic [3:0] min_1s;
        logic [3:0] sec_10s;
        logic [3:0] sec_1s;
    } bcd_time_t;

    typedef struct packed {
        logic       enable;             // Alarm armed
        logic [3:0] hours;
        logic [5:0] minutes;
    } alarm_cfg_t;

    // ********************
    // Register map, AXI codes, limits

    localparam logic [3:0] ADDR_TIME     = 4'h0;
    localparam logic [3:0] ADDR_TIME_BCD = 4'h4;   // Read only
    localparam logic [3:0] ADDR_ALARM    = 4'h8;
    localparam logic [3:0] ADDR_STATUS   = 4'hC;   // Bit 0 is ringing, write 1 clears

    localparam int ALARM_EN_BIT = 16;              // Enable position in alarm word

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    localparam logic [5:0] MAX_SECONDS = 6'd59;
    localparam logic [5:0] MAX_MINUTES = 6'd59;
    localparam logic [3:0] MAX_HOURS   = 4'd12;
    localparam logic [3:0] RESET_HOURS = 4'd12;

    localparam int RING_SECONDS = 30;              // Auto stop after this many ticks
    localparam int RING_CNT_W   = $clog2(RING_SECONDS + 1);

    // Binary fields to BCD digits, one divide and remainder per field
    function automatic bcd_time_t to_bcd(input clock_time_t t);
        bcd_time_t b;
        b.hr_10s  = 4'(t.hours / 10);
        b.hr_1s   = 4'(t.hours % 10);
        b.min_10s = 4'(t.minutes / 10);
        b.min_1s  = 4'(t.minutes % 10);
        b.sec_10s = 4'(t.seconds / 10);
        b.sec_1s  = 4'(t.seconds % 10);
        return b;
    endfunction

endpackage

`default_nettype wire

// File: src/time_keeper.sv
`timescale 1ns/100ps
`default_nettype none

module time_keeper (
    input  logic                  tick_1Hz,    // One edge per second
    input  logic                  reset,
    input  logic                  tick_hr,     // Button, advances hours while held
    input  logic                  tick_min,    // Button, advances minutes while held
    input  logic                  load_valid,  // One cycle load pulse from registers
    input  clock_pkg::clock_time_t load_time,
    output clock_pkg::clock_time_t now
);

    import clock_pkg::*;

    logic       sec_wrap;       // Seconds at 59
    logic       min_wrap;       // Minutes at 59
    logic       min_step;       // Minutes advance this edge
    logic       hr_step;        // Hours advance this edge
    logic [5:0] sec_next;
    logic [5:0] min_next;
    logic [3:0] hr_next;

    // ********************
    // Carry chain

    always_comb begin
        sec_wrap = (now.seconds == MAX_SECONDS);
        min_wrap = (now.minutes == MAX_MINUTES);

        // Button or natural carry
        min_step = tick_min | sec_wrap;
        hr_step  = tick_hr | (min_wrap & sec_wrap);
    end

    // ********************
    // Next field values

    always_comb begin
        // Seconds always move
        if (sec_wrap) begin
            sec_next = '0;
        end else begin
            sec_next = now.seconds + 6'd1;
        end

        min_next = now.minutes;             // Hold by default
        if (min_step) begin
            min_next = min_wrap ? 6'd0 : now.minutes + 6'd1;
        end

        hr_next = now.hours;
        if (hr_step) begin
            // 12 rolls over to 1, no hour zero
            if (now.hours >= MAX_HOURS) begin
                hr_next = 4'd1;
            end else begin
                hr_next = now.hours + 4'd1;
            end
        end
    end

    // ********************
    // Time register

    always_ff @(posedge tick_1Hz or posedge reset) begin
        if (reset) begin
            now.hours   <= RESET_HOURS;     // 12:00:00
            now.minutes <= '0;
            now.seconds <= '0;
        end else if (load_valid) begin
            now <= load_time;               // Load beats counting
        end else begin
            now.seconds <= sec_next;
            now.minutes <= min_next;
            now.hours   <= hr_next;
        end
    end

endmodule

`default_nettype wire

// File: src/alarm_unit.sv
`timescale 1ns/100ps
`default_nettype none

module alarm_unit (
    input  logic                   tick_1Hz,
    input  logic                   reset,
    input  clock_pkg::clock_time_t now,
    input  clock_pkg::alarm_cfg_t  alarm_cfg,
    input  logic                   ring_clear,  // Software stop, one cycle
    output logic                   ringing      // Buzzer drive
);

    import clock_pkg::*;

    logic                  match;       // Alarm time reached this second
    logic                  ring_done;   // Ring period used up
    logic [RING_CNT_W-1:0] ring_cnt;    // Seconds spent ringing

    // ********************
    // Match detect

    always_comb begin
        // Only at the top of the minute, so one trigger per match
        match = alarm_cfg.enable
              & (now.hours == alarm_cfg.hours)
              & (now.minutes == alarm_cfg.minutes)
              & (now.seconds == '0);

        ring_done = (ring_cnt == RING_CNT_W'(RING_SECONDS));
    end

    // ********************
    // Ringing flag and auto stop

    always_ff @(posedge tick_1Hz or posedge reset) begin
        if (reset) begin
            ringing  <= 1'b0;
            ring_cnt <= '0;
        end else if (ringing) begin
            if (ring_clear || ring_done) begin
                ringing  <= 1'b0;           // Cleared or timed out
                ring_cnt <= '0;
            end else begin
                ring_cnt <= ring_cnt + 1'b1;
            end
        end else if (match && !ring_clear) begin
            ringing  <= 1'b1;
            ring_cnt <= RING_CNT_W'(1);     // First ringing second
        end
    end

endmodule

`default_nettype wire

// File: src/clock_regs.sv
`timescale 1ns/100ps
`default_nettype none

module clock_regs (
    input  logic                   tick_1Hz,
    input  logic                   reset,
    // Write address and data
    input  logic [3:0]             awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [31:0]            wdata,
    input  logic                   wvalid,
    output logic                   wready,
    // Write response
    output logic [1:0]             bresp,
    output logic                   bvalid,
    input  logic                   bready,
    // Read address and data
    input  logic [3:0]             araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output logic [31:0]            rdata,
    output logic [1:0]             rresp,
    output logic                   rvalid,
    input  logic                   rready,
    // Clock core side
    input  clock_pkg::clock_time_t now,
    input  logic                   ringing,
    output logic                   load_valid,
    output clock_pkg::clock_time_t load_time,
    output clock_pkg::alarm_cfg_t  alarm_cfg,
    output logic                   ring_clear
);

    import clock_pkg::*;

    logic        wr_fire;       // Write handshake this cycle
    logic        rd_fire;       // Read handshake this cycle
    clock_time_t wr_time;       // Write data seen as a time word
    logic [1:0]  wr_resp;
    logic        wr_load;
    logic        wr_clear;
    logic        wr_alarm;
    logic [31:0] rd_data;
    logic [1:0]  rd_resp;

    // Hours 1 to 12, minutes and seconds to 59
    function automatic logic time_ok(input clock_time_t t);
        return (t.hours >= 4'd1) && (t.hours <= MAX_HOURS)
            && (t.minutes <= MAX_MINUTES) && (t.seconds <= MAX_SECONDS);
    endfunction

    assign wr_fire = awready & awvalid & wvalid;
    assign rd_fire = arready & arvalid;
    assign wr_time = clock_time_t'(wdata[15:0]);

    // ********************
    // Write decode

    always_comb begin
        wr_resp  = RESP_OKAY;
        wr_load  = 1'b0;
        wr_clear = 1'b0;
        wr_alarm = 1'b0;
        case (awaddr)
            ADDR_TIME: begin
                if (time_ok(wr_time)) begin
                    wr_load = 1'b1;
                end else begin
                    wr_resp = RESP_SLVERR;  // Bad time, keep running
                end
            end
            ADDR_ALARM:  wr_alarm = 1'b1;
            ADDR_STATUS: wr_clear = wdata[0];  // Write 1 to clear
            default:     wr_resp = RESP_SLVERR; // BCD view and holes
        endcase
    end

    // ********************
    // Read decode

    always_comb begin
        rd_data = '0;
        rd_resp = RESP_OKAY;
        case (araddr)
            ADDR_TIME:     rd_data = {16'b0, now};
            ADDR_TIME_BCD: rd_data = {8'b0, to_bcd(now)};
            ADDR_ALARM:    rd_data = {15'b0, alarm_cfg.enable, 6'b0,
                                      alarm_cfg.hours, alarm_cfg.minutes};
            ADDR_STATUS:   rd_data = {31'b0, ringing};
            default:       rd_resp = RESP_SLVERR;   // Data stays zero
        endcase
    end

    // ********************
    // Handshake and control state

    always_ff @(posedge tick_1Hz or posedge reset) begin
        if (reset) begin
            awready    <= 1'b0;
            wready     <= 1'b0;
            bvalid     <= 1'b0;
            arready    <= 1'b0;
            rvalid     <= 1'b0;
            load_valid <= 1'b0;
            ring_clear <= 1'b0;
            alarm_cfg  <= '0;
        end else begin
            // Ready pulses for one cycle, none while a response waits
            awready <= awvalid & wvalid & ~awready & ~bvalid;
            wready  <= awvalid & wvalid & ~awready & ~bvalid;
            arready <= arvalid & ~arready & ~rvalid;

            load_valid <= wr_fire & wr_load;    // Same edge as bvalid
            ring_clear <= wr_fire & wr_clear;

            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end

            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end

            if (wr_fire && wr_alarm) begin
                alarm_cfg.enable  <= wdata[ALARM_EN_BIT];
                alarm_cfg.hours   <= wdata[9:6];
                alarm_cfg.minutes <= wdata[5:0];
            end
        end
    end

    // Response and load payload
    always_ff @(posedge tick_1Hz) begin
        if (wr_fire) begin
            bresp     <= wr_resp;
            load_time <= wr_time;
        end
        if (rd_fire) begin
            rdata <= rd_data;                   // Snapshot at acceptance
            rresp <= rd_resp;
        end
    end

endmodule

`default_nettype wire

// File: src/binary_clock_top.sv
`timescale 1ns/100ps
`default_nettype none

module binary_clock_top (
    input  logic                  tick_1Hz,   // System clock, one second per edge
    input  logic                  reset,
    input  logic                  tick_hr,    // Hour set button
    input  logic                  tick_min,   // Minute set button
    // AXI4-Lite slave
    input  logic [3:0]            awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [31:0]           wdata,
    input  logic                  wvalid,
    output logic                  wready,
    output logic [1:0]            bresp,
    output logic                  bvalid,
    input  logic                  bready,
    input  logic [3:0]            araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output logic [31:0]           rdata,
    output logic [1:0]            rresp,
    output logic                  rvalid,
    input  logic                  rready,
    // Display and buzzer
    output clock_pkg::bcd_time_t  display,
    output logic                  ringing
);

    import clock_pkg::*;

    clock_time_t now;           // Running time
    clock_time_t load_time;
    logic        load_valid;
    alarm_cfg_t  alarm_cfg;
    logic        ring_clear;

    clock_regs regs_i (
        .tick_1Hz, .reset,
        .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .now, .ringing, .load_valid, .load_time, .alarm_cfg, .ring_clear
    );

    time_keeper keeper_i (
        .tick_1Hz, .reset, .tick_hr, .tick_min,
        .load_valid, .load_time, .now
    );

    alarm_unit alarm_i (
        .tick_1Hz, .reset, .now, .alarm_cfg, .ring_clear, .ringing
    );

    // Digits for the display, no extra register
    assign display = to_bcd(now);

endmodule

`default_nettype wire

// File: sim/binary_clock_props.sv
`timescale 1ns/100ps
`default_nettype none

module binary_clock_props (
    input logic                   tick_1Hz,
    input logic                   reset,
    input clock_pkg::clock_time_t now,
    input logic                   ringing,
    input logic                   bvalid,
    input logic                   bready,
    input logic                   rvalid,
    input logic                   rready
);

    import clock_pkg::*;

    // ********************
    // Counter ranges

    sec_range: assert property (@(posedge tick_1Hz) disable iff (reset)
        now.seconds <= MAX_SECONDS) else $error("seconds above limit");
    min_range: assert property (@(posedge tick_1Hz) disable iff (reset)
        now.minutes <= MAX_MINUTES) else $error("minutes above limit");
    hr_range: assert property (@(posedge tick_1Hz) disable iff (reset)
        now.hours >= 4'd1 && now.hours <= MAX_HOURS) else $error("hours outside 1 to 12");

    // ********************
    // Alarm and bus rules

    // Auto stop bounds the ring
    ring_limit: assert property (@(posedge tick_1Hz) disable iff (reset)
        $rose(ringing) |-> ##[1:RING_SECONDS] !ringing) else $error("ringing too long");
    b_hold: assert property (@(posedge tick_1Hz) disable iff (reset)
        bvalid && !bready |=> bvalid) else $error("bvalid dropped before bready");
    r_hold: assert property (@(posedge tick_1Hz) disable iff (reset)
        rvalid && !rready |=> rvalid) else $error("rvalid dropped before rready");

endmodule

bind binary_clock_top binary_clock_props props_i (
    .tick_1Hz, .reset, .now, .ringing, .bvalid, .bready, .rvalid, .rready
);

`default_nettype wire

// File: sim/tb_binary_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_binary_clock;

    import clock_pkg::*;

    // ********************
    // Run limits and signals

    localparam int TEST_BUDGET    = 400 + 200 + 600 + 400 + 400;   // Per test, stalls included
    localparam int TIMEOUT_CYCLES = 2 * TEST_BUDGET;

    logic        tick_1Hz, reset, tick_hr, tick_min;
    logic [3:0]  awaddr, araddr;
    logic        awvalid, awready, wvalid, wready, bvalid, bready;
    logic        arvalid, arready, rvalid, rready;
    logic [31:0] wdata, rdata;
    logic [1:0]  bresp, rresp;
    bcd_time_t   display;
    logic        ringing;

    clock_time_t model;                 // Reference time
    clock_time_t load_val;              // Taken by the model on the edge after a write
    logic        load_pend;
    logic [31:0] rng;
    int          cycles, checks, errors, tests, err_base;

    binary_clock_top dut_i (.*);

    initial begin
        tick_1Hz = 1'b0;
        forever #20 tick_1Hz = ~tick_1Hz;   // 40 ns period
    end

    // ********************
    // Reference model

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // One second forward, buttons force the minute or hour carry
    function automatic clock_time_t advance_time(input clock_time_t t, input logic hr_btn,
                                                 input logic min_btn);
        int s, m, h;
        logic sec_carry, min_carry;
        s = t.seconds + 1;
        m = t.minutes;
        h = t.hours;
        sec_carry = (s == 60);
        min_carry = sec_carry && (m == 59);
        if (sec_carry) s = 0;
        if (min_btn || sec_carry) m = (m + 1) % 60;
        if (hr_btn || min_carry) h = h % 12 + 1;   // 12 goes to 1
        return {4'(h), 6'(m), 6'(s)};
    endfunction

    function automatic logic [23:0] bcd_of(input clock_time_t t);
        int h, m, s;
        h = t.hours;
        m = t.minutes;
        s = t.seconds;
        return {4'(h / 10), 4'(h % 10), 4'(m / 10), 4'(m % 10), 4'(s / 10), 4'(s % 10)};
    endfunction

    function automatic logic legal_time(input clock_time_t t);
        return t.hours >= 1 && t.hours <= 12 && t.minutes < 60 && t.seconds < 60;
    endfunction

    function automatic logic [31:0] time_word(input int h, input int m, input int s);
        return {16'b0, 4'(h), 6'(m), 6'(s)};
    endfunction

    function automatic logic [31:0] alarm_word(input logic en, input int h, input int m);
        return {15'b0, en, 6'b0, 4'(h), 6'(m)};     // Enable at bit 16
    endfunction

    always @(posedge tick_1Hz or posedge reset) begin
        if (reset) begin
            model <= {4'd12, 6'd0, 6'd0};
        end else if (load_pend) begin
            model <= load_val;                  // Register write lands here
        end else begin
            model <= advance_time(model, tick_hr, tick_min);
        end
    end

    // ********************
    // Check and bus helpers

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic end_test(input string name);
        $display("%s: finished with %0d errors", name, errors - err_base);
        err_base = errors;
        tests++;
    endtask

    task automatic idle_random();
        rng = xorshift(rng);
        repeat (rng % 4) @(posedge tick_1Hz);
    endtask

    task automatic check_display(input string name, input int n);
        repeat (n) begin
            @(negedge tick_1Hz);
            check_value(name, bcd_of(model), display);
        end
    endtask

    task automatic wait_for_time(input int h, input int m);
        @(negedge tick_1Hz);
        while (model != {4'(h), 6'(m), 6'd0}) @(negedge tick_1Hz);
    endtask

    task automatic axi_write(input string name, input logic [3:0] addr, input logic [31:0] data,
                             input logic [1:0] exp_resp);
        idle_random();
        @(posedge tick_1Hz);
        awaddr  <= addr;
        wdata   <= data;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        @(negedge tick_1Hz);
        while (!awready) @(negedge tick_1Hz);
        check_value({name, " wready"}, 1, wready);  // Both readies in the same cycle
        @(posedge tick_1Hz);                        // Handshake edge
        awvalid   <= 1'b0;
        wvalid    <= 1'b0;
        load_val  <= data[15:0];
        load_pend <= (addr == ADDR_TIME) && legal_time(data[15:0]);
        @(posedge tick_1Hz);
        load_pend <= 1'b0;
        idle_random();                              // bready stall
        bready <= 1'b1;
        @(negedge tick_1Hz);
        while (!bvalid) @(negedge tick_1Hz);
        check_value({name, " bresp"}, exp_resp, bresp);
        @(posedge tick_1Hz);
        bready <= 1'b0;
    endtask

    task automatic axi_read(input string name, input logic [3:0] addr, input logic [1:0] exp_resp,
                            output logic [31:0] data, output clock_time_t snap);
        idle_random();
        @(posedge tick_1Hz);
        araddr  <= addr;
        arvalid <= 1'b1;
        @(negedge tick_1Hz);
        while (!arready) @(negedge tick_1Hz);
        snap = model;                               // Time captured on the next edge
        @(posedge tick_1Hz);
        arvalid <= 1'b0;
        idle_random();                              // rready stall
        rready <= 1'b1;
        @(negedge tick_1Hz);
        while (!rvalid) @(negedge tick_1Hz);
        data = rdata;
        check_value({name, " rresp"}, exp_resp, rresp);
        @(posedge tick_1Hz);
        rready <= 1'b0;
    endtask

    // ********************
    // Test sequence

    initial begin
        logic [31:0] data;
        clock_time_t snap;
        int n;
        rng = 32'h8f03;
        {checks, errors, tests, err_base} = '0;
        reset = 1'b1;
        {tick_hr, tick_min, awvalid, wvalid, bready, arvalid, rready} = '0;
        {awaddr, araddr, wdata} = '0;
        {load_pend, load_val} = '0;
        repeat (10) @(posedge tick_1Hz);
        reset <= 1'b0;

        @(negedge tick_1Hz);                        // Free run and wraps
        check_value("reset_time", 32'h120000, display);
        check_value("reset_ring", 0, ringing);
        check_display("free_run", 70);
        axi_write("load_wrap", ADDR_TIME, time_word(12, 59, 50), RESP_OKAY);
        check_display("hour_wrap", 20);             // Through 1:00:00
        end_test("free_run");

        @(posedge tick_1Hz);                        // Held buttons
        tick_min <= 1'b1;
        repeat (7) @(posedge tick_1Hz);
        tick_min <= 1'b0;
        tick_hr  <= 1'b1;
        repeat (5) @(posedge tick_1Hz);
        tick_hr <= 1'b0;
        check_display("buttons", 3);
        end_test("buttons");

        axi_write("time_ok", ADDR_TIME, time_word(7, 30, 15), RESP_OKAY);
        axi_read("read_time", ADDR_TIME, RESP_OKAY, data, snap);
        check_value("read_time", {16'b0, snap}, data);
        axi_read("read_bcd", ADDR_TIME_BCD, RESP_OKAY, data, snap);
        check_value("read_bcd", {8'b0, bcd_of(snap)}, data);
        axi_write("bad_hour", ADDR_TIME, time_word(13, 0, 0), RESP_SLVERR);
        axi_write("zero_hour", ADDR_TIME, time_word(0, 10, 0), RESP_SLVERR);
        axi_write("bad_min", ADDR_TIME, time_word(5, 60, 0), RESP_SLVERR);
        axi_write("bad_sec", ADDR_TIME, time_word(5, 10, 60), RESP_SLVERR);
        axi_write("bcd_write", ADDR_TIME_BCD, time_word(1, 2, 3), RESP_SLVERR);
        axi_read("after_bad", ADDR_TIME, RESP_OKAY, data, snap);
        check_value("after_bad", {16'b0, snap}, data);
        axi_read("unmapped", 4'h2, RESP_SLVERR, data, snap);
        check_value("unmapped", 0, data);
        end_test("registers");

        axi_write("alarm_set", ADDR_ALARM, alarm_word(1'b1, 4, 0), RESP_OKAY);
        axi_read("alarm_read", ADDR_ALARM, RESP_OKAY, data, snap);
        check_value("alarm_read", alarm_word(1'b1, 4, 0), data);
        axi_write("time_359", ADDR_TIME, time_word(3, 59, 45), RESP_OKAY);
        wait_for_time(4, 0);
        check_value("ring_before", 0, ringing);
        n = 0;
        @(negedge tick_1Hz);
        while (ringing && n <= RING_SECONDS) begin  // Count ringing seconds
            n++;
            @(negedge tick_1Hz);
        end
        check_value("ring_length", RING_SECONDS, n);
        end_test("alarm_timeout");

        axi_write("alarm_5", ADDR_ALARM, alarm_word(1'b1, 5, 0), RESP_OKAY);
        axi_write("time_459", ADDR_TIME, time_word(4, 59, 45), RESP_OKAY);
        wait_for_time(5, 0);
        @(negedge tick_1Hz);
        check_value("ring_start", 1, ringing);
        axi_write("clear", ADDR_STATUS, 32'h1, RESP_OKAY);
        @(negedge tick_1Hz);
        check_value("ring_cleared", 0, ringing);
        axi_read("status", ADDR_STATUS, RESP_OKAY, data, snap);
        check_value("status", 0, data);
        axi_write("alarm_off", ADDR_ALARM, alarm_word(1'b0, 6, 0), RESP_OKAY);
        axi_write("time_559", ADDR_TIME, time_word(5, 59, 50), RESP_OKAY);
        wait_for_time(6, 0);
        repeat (3) begin
            @(negedge tick_1Hz);
            check_value("disabled", 0, ringing);
        end
        end_test("alarm_clear");

        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge tick_1Hz);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: binary_clock_top.f
src/clock_pkg.sv
src/time_keeper.sv
src/alarm_unit.sv
src/clock_regs.sv
src/binary_clock_top.sv
sim/binary_clock_props.sv
sim/tb_binary_clock.sv
